// File: rtl/core_pkg.sv
package core_pkg;

	// id_ex stall codes
	typedef enum logic [1:0] {
		STALL_NEXT = 2'b00,
		STALL_KEEP = 2'b01,
		STALL_ZERO = 2'b10
	} stall_t;

	typedef enum logic [3:0] {
		ALU_ZERO = 4'd0,
		ALU_ADD  = 4'd1,
		ALU_SUB  = 4'd2,
		ALU_AND  = 4'd3,
		ALU_OR   = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SLL  = 4'd6,
		ALU_SRL  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_LUI  = 4'd9
	} alu_op_t;

	typedef enum logic {
		OP2_REG = 1'b0,
		OP2_IMM = 1'b1
	} op2_src_t;

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	// funct3 encodings shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL = 3'b101;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	localparam int REG_ADDR_W = 5;
	localparam int INST_W     = 32;

endpackage

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [REG_ADDR_W-1:0] rs1_addr,
	input  logic [REG_ADDR_W-1:0] rs2_addr,
	input  logic                  wena,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic [XLEN-1:0]       wdata,
	output logic [XLEN-1:0]       rs1_data,
	output logic [XLEN-1:0]       rs2_data
);

	logic [XLEN-1:0] regs [32];
	logic            wr_live;

	// x0 is never written so it stays at its reset value of zero
	assign wr_live = wena && (waddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[waddr] <= wdata;
		end
	end

	// write-first bypass
	assign rs1_data = (wr_live && waddr == rs1_addr) ? wdata : regs[rs1_addr];
	assign rs2_data = (wr_live && waddr == rs2_addr) ? wdata : regs[rs2_addr];

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import core_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic                  inst_valid,
	input  logic [INST_W-1:0]     inst,
	input  logic [XLEN-1:0]       inst_pc,
	input  logic [XLEN-1:0]       rs1_data,
	input  logic [XLEN-1:0]       rs2_data,
	output logic [REG_ADDR_W-1:0] rs1_addr,
	output logic [REG_ADDR_W-1:0] rs2_addr,
	output logic                  uses_rs2,
	output logic                  id_valid,
	output logic [XLEN-1:0]       id_pc,
	output logic [INST_W-1:0]     id_inst,
	output logic [REG_ADDR_W-1:0] id_rs1_addr,
	output logic [REG_ADDR_W-1:0] id_rs2_addr,
	output logic [XLEN-1:0]       id_rs1_data,
	output logic [XLEN-1:0]       id_rs2_data,
	output logic [XLEN-1:0]       id_imm,
	output op2_src_t              id_op2_src,
	output alu_op_t               id_alu_op,
	output logic                  id_rd_wena,
	output logic [REG_ADDR_W-1:0] id_rd_waddr
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       supported;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		id_alu_op  = ALU_ZERO;
		id_op2_src = OP2_REG;
		id_imm     = '0;
		supported  = 1'b0;
		unique case (opcode)
			OPC_OP: begin
				supported = 1'b1;
				if (funct7 == F7_ALT && funct3 == F3_ADD) begin
					id_alu_op = ALU_SUB;
				end else if (funct7 == F7_BASE) begin
					case (funct3)
						F3_ADD: id_alu_op = ALU_ADD;
						F3_SLL: id_alu_op = ALU_SLL;
						F3_SLT: id_alu_op = ALU_SLT;
						F3_XOR: id_alu_op = ALU_XOR;
						F3_SRL: id_alu_op = ALU_SRL;
						F3_OR:  id_alu_op = ALU_OR;
						F3_AND: id_alu_op = ALU_AND;
						default: supported = 1'b0;
					endcase
				end else begin
					supported = 1'b0;
				end
			end
			OPC_OP_IMM: begin
				id_op2_src = OP2_IMM;
				id_imm     = XLEN'($signed(inst[31:20]));
				supported  = 1'b1;
				case (funct3)
					F3_ADD: id_alu_op = ALU_ADD;
					F3_XOR: id_alu_op = ALU_XOR;
					F3_OR:  id_alu_op = ALU_OR;
					F3_AND: id_alu_op = ALU_AND;
					default: supported = 1'b0;
				endcase
			end
			OPC_LUI: begin
				id_op2_src = OP2_IMM;
				id_imm     = XLEN'($signed({inst[31:12], 12'h000}));
				id_alu_op  = ALU_LUI;
				supported  = 1'b1;
			end
			default: ;
		endcase
		if (!supported) begin
			id_alu_op = ALU_ZERO;
		end
	end

	// only register-register ops read rs2, LUI reads nothing
	assign uses_rs2 = (opcode == OPC_OP);
	assign rs1_addr = (opcode == OPC_LUI) ? '0 : inst[19:15];
	assign rs2_addr = uses_rs2 ? inst[24:20] : '0;

	assign id_valid    = inst_valid;
	assign id_pc       = inst_pc;
	assign id_inst     = inst;
	assign id_rs1_addr = rs1_addr;
	assign id_rs2_addr = rs2_addr;
	assign id_rs1_data = rs1_data;
	assign id_rs2_data = rs2_data;
	assign id_rd_wena  = inst_valid && supported;
	assign id_rd_waddr = inst[11:7];

endmodule

// File: rtl/id_ex.sv
`timescale 1ns/1ps

module id_ex import core_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  stall_t                stall,

	input  logic                  id_valid,
	input  logic [XLEN-1:0]       id_pc,
	input  logic [INST_W-1:0]     id_inst,
	input  logic [REG_ADDR_W-1:0] id_rs1_addr,
	input  logic [REG_ADDR_W-1:0] id_rs2_addr,
	input  logic [XLEN-1:0]       id_rs1_data,
	input  logic [XLEN-1:0]       id_rs2_data,
	input  logic [XLEN-1:0]       id_imm,
	input  op2_src_t              id_op2_src,
	input  alu_op_t               id_alu_op,
	input  logic                  id_rd_wena,
	input  logic [REG_ADDR_W-1:0] id_rd_waddr,

	output logic                  ex_valid,
	output logic [XLEN-1:0]       ex_pc,
	output logic [INST_W-1:0]     ex_inst,
	output logic [REG_ADDR_W-1:0] ex_rs1_addr,
	output logic [REG_ADDR_W-1:0] ex_rs2_addr,
	output logic [XLEN-1:0]       ex_rs1_data,
	output logic [XLEN-1:0]       ex_rs2_data,
	output logic [XLEN-1:0]       ex_imm,
	output op2_src_t              ex_op2_src,
	output alu_op_t               ex_alu_op,
	output logic                  ex_rd_wena,
	output logic [REG_ADDR_W-1:0] ex_rd_waddr
);

	logic clear;

	// bubble on STALL_ZERO and on any undefined code
	assign clear = rst || !(stall inside {STALL_NEXT, STALL_KEEP});

	always_ff @(posedge clk) begin
		if (clear) begin
			ex_valid    <= 1'b0;
			ex_pc       <= '0;
			ex_inst     <= '0;
			ex_rs1_addr <= '0;
			ex_rs2_addr <= '0;
			ex_rs1_data <= '0;
			ex_rs2_data <= '0;
			ex_imm      <= '0;
			ex_op2_src  <= OP2_REG;
			ex_alu_op   <= ALU_ZERO;
			ex_rd_wena  <= 1'b0;
			ex_rd_waddr <= '0;
		end else if (stall == STALL_NEXT) begin
			ex_valid    <= id_valid;
			ex_pc       <= id_pc;
			ex_inst     <= id_inst;
			ex_rs1_addr <= id_rs1_addr;
			ex_rs2_addr <= id_rs2_addr;
			ex_rs1_data <= id_rs1_data;
			ex_rs2_data <= id_rs2_data;
			ex_imm      <= id_imm;
			ex_op2_src  <= id_op2_src;
			ex_alu_op   <= id_alu_op;
			ex_rd_wena  <= id_rd_wena;
			ex_rd_waddr <= id_rd_waddr;
		end
		// STALL_KEEP leaves everything in place
	end

endmodule

// File: rtl/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl import core_pkg::*; (
	input  logic                  hold,
	input  logic                  rst,
	input  logic [REG_ADDR_W-1:0] id_rs1_addr,
	input  logic [REG_ADDR_W-1:0] id_rs2_addr,
	input  logic                  uses_rs2,
	input  logic                  ex_valid,
	input  logic                  ex_rd_wena,
	input  logic [REG_ADDR_W-1:0] ex_rd_waddr,
	output stall_t                stall,
	output logic                  inst_ready
);

	logic ex_writes;
	logic raw_rs1;
	logic raw_rs2;

	// x0 never carries a dependency
	assign ex_writes = ex_valid && ex_rd_wena && (ex_rd_waddr != '0);
	assign raw_rs1   = ex_writes && (id_rs1_addr == ex_rd_waddr);
	assign raw_rs2   = ex_writes && uses_rs2 && (id_rs2_addr == ex_rd_waddr);

	always_comb begin
		if (rst) begin
			stall      = STALL_ZERO;
			inst_ready = 1'b0;
		end else if (hold) begin
			stall      = STALL_KEEP;
			inst_ready = 1'b0;
		end else if (raw_rs1 || raw_rs2) begin
			// one bubble lets the producer reach the write port
			stall      = STALL_ZERO;
			inst_ready = 1'b0;
		end else begin
			stall      = STALL_NEXT;
			inst_ready = 1'b1;
		end
	end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import core_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  hold,
	input  logic                  ex_valid,
	input  logic [XLEN-1:0]       ex_pc,
	input  logic [INST_W-1:0]     ex_inst,
	input  logic [REG_ADDR_W-1:0] ex_rs1_addr,
	input  logic [REG_ADDR_W-1:0] ex_rs2_addr,
	input  logic [XLEN-1:0]       ex_rs1_data,
	input  logic [XLEN-1:0]       ex_rs2_data,
	input  logic [XLEN-1:0]       ex_imm,
	input  op2_src_t              ex_op2_src,
	input  alu_op_t               ex_alu_op,
	input  logic                  ex_rd_wena,
	input  logic [REG_ADDR_W-1:0] ex_rd_waddr,
	output logic                  rf_wena,
	output logic [REG_ADDR_W-1:0] rf_waddr,
	output logic [XLEN-1:0]       rf_wdata,
	output logic                  retire_valid,
	output logic [XLEN-1:0]       retire_pc,
	output logic [INST_W-1:0]     retire_inst,
	output logic [REG_ADDR_W-1:0] retire_rd,
	output logic                  retire_wena,
	output logic [XLEN-1:0]       retire_data
);

	localparam int SHAMT_W = (XLEN == 64) ? 6 : 5;

	logic [XLEN-1:0]    op1;
	logic [XLEN-1:0]    op2;
	logic [SHAMT_W-1:0] shamt;
	logic [XLEN-1:0]    result;

	// x0 operands read as zero
	assign op1   = (ex_rs1_addr == '0) ? '0 : ex_rs1_data;
	assign op2   = (ex_op2_src == OP2_IMM) ? ex_imm :
	               (ex_rs2_addr == '0) ? '0 : ex_rs2_data;
	assign shamt = op2[SHAMT_W-1:0];

	always_comb begin
		case (ex_alu_op)
			ALU_ADD: result = op1 + op2;
			ALU_SUB: result = op1 - op2;
			ALU_AND: result = op1 & op2;
			ALU_OR:  result = op1 | op2;
			ALU_XOR: result = op1 ^ op2;
			ALU_SLL: result = op1 << shamt;
			ALU_SRL: result = op1 >> shamt;
			ALU_SLT: result = XLEN'($signed(op1) < $signed(op2));
			ALU_LUI: result = op2;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			retire_wena  <= 1'b0;
		end else if (!hold) begin
			retire_valid <= ex_valid;
			retire_wena  <= ex_rd_wena;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			retire_pc   <= ex_pc;
			retire_inst <= ex_inst;
			retire_rd   <= ex_rd_waddr;
			retire_data <= result;
		end
	end

	// write back at the edge that closes the retire cycle
	assign rf_wena  = retire_valid && retire_wena && !hold;
	assign rf_waddr = retire_rd;
	assign rf_wdata = retire_data;

endmodule

// File: rtl/alu_core_top.sv
`timescale 1ns/1ps

module alu_core_top import core_pkg::*; #(
	parameter int XLEN = 64
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inst_valid,
	input  logic [INST_W-1:0]     inst,
	input  logic [XLEN-1:0]       inst_pc,
	input  logic                  hold,
	output logic                  inst_ready,
	output logic                  retire_valid,
	output logic [XLEN-1:0]       retire_pc,
	output logic [INST_W-1:0]     retire_inst,
	output logic [REG_ADDR_W-1:0] retire_rd,
	output logic                  retire_wena,
	output logic [XLEN-1:0]       retire_data
);

	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic                  uses_rs2;
	stall_t                stall;

	logic                  id_valid;
	logic [XLEN-1:0]       id_pc;
	logic [INST_W-1:0]     id_inst;
	logic [REG_ADDR_W-1:0] id_rs1_addr;
	logic [REG_ADDR_W-1:0] id_rs2_addr;
	logic [XLEN-1:0]       id_rs1_data;
	logic [XLEN-1:0]       id_rs2_data;
	logic [XLEN-1:0]       id_imm;
	op2_src_t              id_op2_src;
	alu_op_t               id_alu_op;
	logic                  id_rd_wena;
	logic [REG_ADDR_W-1:0] id_rd_waddr;

	logic                  ex_valid;
	logic [XLEN-1:0]       ex_pc;
	logic [INST_W-1:0]     ex_inst;
	logic [REG_ADDR_W-1:0] ex_rs1_addr;
	logic [REG_ADDR_W-1:0] ex_rs2_addr;
	logic [XLEN-1:0]       ex_rs1_data;
	logic [XLEN-1:0]       ex_rs2_data;
	logic [XLEN-1:0]       ex_imm;
	op2_src_t              ex_op2_src;
	alu_op_t               ex_alu_op;
	logic                  ex_rd_wena;
	logic [REG_ADDR_W-1:0] ex_rd_waddr;

	logic                  rf_wena;
	logic [REG_ADDR_W-1:0] rf_waddr;
	logic [XLEN-1:0]       rf_wdata;

	reg_file #(.XLEN(XLEN)) i_reg_file (
		.wena  (rf_wena),
		.waddr (rf_waddr),
		.wdata (rf_wdata),
		.*
	);

	decode_stage #(.XLEN(XLEN)) i_decode_stage (.*);

	id_ex #(.XLEN(XLEN)) i_id_ex (.*);

	hazard_ctrl i_hazard_ctrl (.*);

	execute_stage #(.XLEN(XLEN)) i_execute_stage (.*);

endmodule

// File: tb/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [31:0]     lfsr_state = 32'h8a18_4a73;
logic [XLEN-1:0] model_regs [32];

// galois LFSR stepped once per bit taken
// the newest bit lands in the lsb
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_state[0]};
		if (lfsr_state[0]) begin
			lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
		end else begin
			lfsr_state = lfsr_state >> 1;
		end
	end
	return v;
endfunction

function automatic void clear_model();
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
endfunction

// random instruction with register indices limited to x0..x7
function automatic logic [31:0] gen_inst();
	logic [3:0] kind;
	logic [2:0] sel;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [2:0] f3;
	logic [6:0] f7;
	kind = 4'(rand_bits(4));
	sel  = 3'(rand_bits(3));
	rd   = 5'(rand_bits(3));
	rs1  = 5'(rand_bits(3));
	rs2  = 5'(rand_bits(3));
	if (kind < 4'd7) begin
		f7 = (sel == 3'd1) ? 7'b0100000 : 7'b0000000;
		case (sel)
			3'd0, 3'd1: f3 = 3'b000;
			3'd2: f3 = 3'b111;
			3'd3: f3 = 3'b110;
			3'd4: f3 = 3'b100;
			3'd5: f3 = 3'b001;
			3'd6: f3 = 3'b101;
			default: f3 = 3'b010;
		endcase
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	end else if (kind < 4'd12) begin
		case (sel[1:0])
			2'd0: f3 = 3'b000;
			2'd1: f3 = 3'b111;
			2'd2: f3 = 3'b110;
			default: f3 = 3'b100;
		endcase
		return {12'(rand_bits(12)), rs1, f3, rd, 7'b0010011};
	end else if (kind < 4'd15) begin
		return {20'(rand_bits(20)), rd, 7'b0110111};
	end
	// sltu, mul, slli and a load lie outside the subset
	case (sel[1:0])
		2'd0: return {7'b0000000, rs2, rs1, 3'b011, rd, 7'b0110011};
		2'd1: return {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
		2'd2: return {12'h003, rs1, 3'b001, rd, 7'b0010011};
		default: return {12'h010, rs1, 3'b011, rd, 7'b0000011};
	endcase
endfunction

// executes one instruction on the model register file
function automatic void ref_exec(input logic [31:0] in, output logic [4:0] rd,
		output logic wena, output logic [XLEN-1:0] data);
	logic [6:0]      opc;
	logic [2:0]      f3;
	logic [6:0]      f7;
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [XLEN-1:0] imm;
	int              shamt;
	opc   = in[6:0];
	f3    = in[14:12];
	f7    = in[31:25];
	rd    = in[11:7];
	imm   = {{(XLEN-12){in[31]}}, in[31:20]};
	a     = model_regs[in[19:15]];
	b     = (opc == 7'b0010011) ? imm : model_regs[in[24:20]];
	shamt = (XLEN == 64) ? int'(b[5:0]) : int'(b[4:0]);
	wena  = 1'b1;
	data  = '0;
	if (opc == 7'b0110011 && f7 == 7'b0100000 && f3 == 3'b000) begin
		data = a - b;
	end else if (opc == 7'b0110011 && f7 == 7'b0000000) begin
		case (f3)
			3'b000: data = a + b;
			3'b001: data = a << shamt;
			// differing signs decide on their own, equal signs compare as unsigned
			3'b010: data = XLEN'((a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b));
			3'b100: data = a ^ b;
			3'b101: data = a >> shamt;
			3'b110: data = a | b;
			3'b111: data = a & b;
			default: wena = 1'b0;
		endcase
	end else if (opc == 7'b0010011) begin
		case (f3)
			3'b000: data = a + b;
			3'b100: data = a ^ b;
			3'b110: data = a | b;
			3'b111: data = a & b;
			default: wena = 1'b0;
		endcase
	end else if (opc == 7'b0110111) begin
		data = {{(XLEN-31){in[31]}}, in[30:12], 12'h000};
	end else begin
		wena = 1'b0;
	end
	// x0 keeps its zero
	if (wena && rd != 5'd0) begin
		model_regs[rd] = data;
	end
endfunction

`endif

// File: tb/tb_alu_core.sv
`timescale 1ns/1ps

module tb_alu_core;

	localparam int XLEN           = 64;
	localparam int NUM_INST       = 400;
	localparam int TIMEOUT_CYCLES = NUM_INST * 4 + 200;
	localparam logic [XLEN-1:0] PC_BASE = XLEN'(32'h8000_0000);

	logic            clk;
	logic            rst;
	logic            inst_valid;
	logic [31:0]     inst;
	logic [XLEN-1:0] inst_pc;
	logic            hold;
	logic            inst_ready;
	logic            retire_valid;
	logic [XLEN-1:0] retire_pc;
	logic [31:0]     retire_inst;
	logic [4:0]      retire_rd;
	logic            retire_wena;
	logic [XLEN-1:0] retire_data;

	// accepted instructions waiting for retirement
	logic [XLEN-1:0] pc_q [$];
	logic [31:0]     inst_q [$];

	int cycle_count = 0;
	int retired     = 0;
	int value_errs  = 0;
	int other_errs  = 0;

	`include "ref_model.svh"

	alu_core_top #(.XLEN(XLEN)) i_alu_core_top (
		.clk          (clk),
		.rst          (rst),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.inst_pc      (inst_pc),
		.hold         (hold),
		.inst_ready   (inst_ready),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.retire_rd    (retire_rd),
		.retire_wena  (retire_wena),
		.retire_data  (retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic compare_field(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		assert (actual === expected) else begin
			value_errs++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// wait for the next edge, report acceptance, then redraw hold
	task automatic step_clock(output logic taken);
		@(posedge clk);
		taken = inst_valid && inst_ready;
		#1;
		hold = (rand_bits(3) == 32'd0);
	endtask

	task automatic print_summary();
		$display("errors: %0d value, %0d protocol; %0d of %0d instructions retired",
			value_errs, other_errs, retired, NUM_INST);
	endtask

	always @(posedge clk) begin
		logic [XLEN-1:0] exp_pc;
		logic [31:0]     exp_inst;
		logic [4:0]      exp_rd;
		logic            exp_wena;
		logic [XLEN-1:0] exp_data;
		cycle_count++;
		if (rst) begin
			compare_field("inst_ready", '0, XLEN'(inst_ready));
			if (cycle_count > 1) begin
				compare_field("retire_valid", '0, XLEN'(retire_valid));
			end
		end else begin
			if (hold) begin
				compare_field("inst_ready", '0, XLEN'(inst_ready));
			end
			if (inst_valid && inst_ready) begin
				pc_q.push_back(inst_pc);
				inst_q.push_back(inst);
			end
			if (retire_valid && !hold) begin
				assert (inst_q.size() > 0) else begin
					other_errs++;
					$display("%0t: retirement seen with no instruction outstanding", $time);
				end
				if (inst_q.size() > 0) begin
					exp_pc   = pc_q.pop_front();
					exp_inst = inst_q.pop_front();
					ref_exec(exp_inst, exp_rd, exp_wena, exp_data);
					compare_field("retire_pc", exp_pc, retire_pc);
					compare_field("retire_inst", XLEN'(exp_inst), XLEN'(retire_inst));
					compare_field("retire_rd", XLEN'(exp_rd), XLEN'(retire_rd));
					compare_field("retire_wena", XLEN'(exp_wena), XLEN'(retire_wena));
					compare_field("retire_data", exp_data, retire_data);
					retired++;
				end
			end
		end
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		$display("timeout after %0d cycles with %0d instructions outstanding",
			cycle_count, NUM_INST - retired);
		print_summary();
		$display("TB FAILED");
		$finish;
	end

	initial begin
		logic taken;
		rst        = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		inst_pc    = '0;
		hold       = 1'b0;
		clear_model();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int n = 0; n < NUM_INST; n++) begin
			// random idle gaps between instructions
			while (rand_bits(2) == 32'd0) begin
				inst_valid = 1'b0;
				step_clock(taken);
			end
			inst_valid = 1'b1;
			inst       = gen_inst();
			inst_pc    = PC_BASE + XLEN'(4 * n);
			taken      = 1'b0;
			while (!taken) begin
				step_clock(taken);
			end
		end
		inst_valid = 1'b0;
		while (retired < NUM_INST) begin
			step_clock(taken);
		end
		hold = 1'b0;
		// quiet cycles to catch a stray retirement
		repeat (4) @(posedge clk);
		print_summary();
		if (value_errs == 0 && other_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+tb
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/id_ex.sv
rtl/hazard_ctrl.sv
rtl/execute_stage.sv
rtl/alu_core_top.sv
tb/tb_alu_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the result.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_alu_core -f sim.f -o Vtb_alu_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_alu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
